// File: logic/mem_edge_pkg.sv
package mem_edge_pkg;

    // ====================
    // Request field widths
    // ====================

    // Line address and line data, data kept narrow for simulation
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 64;
    localparam int MDATA_W = 16;

    // Metadata bit reserved for reads issued on behalf of the page table walker
    localparam int WALK_TAG_BIT = 15;

    // ====================
    // Write heap geometry
    // ====================

    // A multi-beat write shares one heap slot across all of its beats
    localparam int MAX_BEATS  = 4;
    localparam int BEAT_W     = 2;
    localparam int HEAP_SLOTS = 8;
    localparam int SLOT_W     = 3;

    // Heap entries are addressed as {slot, beat}
    localparam int HEAP_DEPTH  = HEAP_SLOTS * MAX_BEATS;
    localparam int HEAP_ADDR_W = SLOT_W + BEAT_W;

    // ====================
    // Enumerations
    // ====================

    // Page table walker port progress through one four-phase transaction
    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_ISSUE,
        WALK_WAIT,
        WALK_ACK
    } walk_state_t;

    // Opcode placed on the memory read channel
    typedef enum logic [1:0] {
        OP_NONE,
        OP_RD_LINE,
        OP_WR_LINE
    } req_op_t;

endpackage

// File: logic/walk_read_port.sv
module walk_read_port
    import mem_edge_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    // Four-phase handshake with the page table walker
    input  logic              walk_req,
    input  logic [ADDR_W-1:0] walk_addr,
    output logic              walk_ack,
    output logic [DATA_W-1:0] walk_data,

    // Read issue toward the request merger
    input  logic              rd_almost_full,
    output logic              issue_valid,
    output logic [ADDR_W-1:0] issue_addr,

    // Tagged read response from the response steering block
    input  logic              rsp_tagged,
    input  logic [DATA_W-1:0] rsp_data
);

    walk_state_t       state;
    logic [ADDR_W-1:0] req_addr;

    // The read goes out in the first ISSUE cycle where the channel has room
    assign issue_valid = (state == WALK_ISSUE) && !rd_almost_full;
    assign issue_addr  = req_addr;

    // Ack is held for as long as the walker keeps its request up
    assign walk_ack = (state == WALK_ACK);

    always_ff @(posedge clk)
    begin
        case (state)
            WALK_IDLE:
            begin
                // A request seen in IDLE is a new rising edge, since the walker
                // only raises it while ack is low
                if (walk_req)
                begin
                    req_addr <= walk_addr;
                    state    <= WALK_ISSUE;
                end
            end
            WALK_ISSUE:
            begin
                if (issue_valid)
                begin
                    state <= WALK_WAIT;
                end
            end
            WALK_WAIT:
            begin
                // Only one walker read is ever outstanding, so any tagged
                // response belongs to it
                if (rsp_tagged)
                begin
                    walk_data <= rsp_data;
                    state     <= WALK_ACK;
                end
            end
            default:
            begin
                if (!walk_req)
                begin
                    state <= WALK_IDLE;
                end
            end
        endcase

        if (reset)
        begin
            state <= WALK_IDLE;
        end
    end

endmodule

// File: logic/read_req_merge.sv
module read_req_merge
    import mem_edge_pkg::*;
(
    // Accelerator read requests
    input  logic               afu_rd_valid,
    input  logic [ADDR_W-1:0]  afu_rd_addr,
    input  logic [MDATA_W-1:0] afu_rd_mdata,
    output logic               afu_rd_ready,

    // Read issued by the walker port
    input  logic               walk_issue_valid,
    input  logic [ADDR_W-1:0]  walk_issue_addr,

    // Memory read channel
    input  logic               mem_rd_almost_full,
    output logic               mem_rd_valid,
    output req_op_t            mem_rd_op,
    output logic [ADDR_W-1:0]  mem_rd_addr,
    output logic [MDATA_W-1:0] mem_rd_mdata
);

    // ====================
    // Request selection
    // ====================

    // The walker takes the slot whenever it is issuing, and the accelerator
    // stalls for that cycle
    assign afu_rd_ready = !mem_rd_almost_full && !walk_issue_valid;

    always_comb
    begin
        // Accelerator requests pass through in the same cycle
        mem_rd_valid = afu_rd_valid && !mem_rd_almost_full;
        mem_rd_addr  = afu_rd_addr;
        mem_rd_mdata = afu_rd_mdata;

        // walk_issue_valid already implies the channel has room
        if (walk_issue_valid)
        begin
            // Walker reads carry only the reserved tag bit in their metadata
            mem_rd_valid = 1'b1;
            mem_rd_addr  = walk_issue_addr;
            mem_rd_mdata = '0;
            mem_rd_mdata[WALK_TAG_BIT] = 1'b1;
        end

        // Every issued request on this channel is a line read
        mem_rd_op = mem_rd_valid ? OP_RD_LINE : OP_NONE;
    end

endmodule

// File: logic/read_rsp_steer.sv
module read_rsp_steer
    import mem_edge_pkg::*;
(
    input  logic               clk,
    input  logic               reset,

    // Read responses from memory
    input  logic               mem_rsp_valid,
    input  logic [MDATA_W-1:0] mem_rsp_mdata,
    input  logic [DATA_W-1:0]  mem_rsp_data,

    // Walker side, decided in the same cycle as the response
    output logic               rsp_tagged,
    output logic [DATA_W-1:0]  rsp_data_out,

    // Accelerator side
    output logic               afu_rsp_valid,
    output logic [MDATA_W-1:0] afu_rsp_mdata,
    output logic [DATA_W-1:0]  afu_rsp_data
);

    logic is_walk_rsp;

    // The reserved bit alone decides the destination
    assign is_walk_rsp  = mem_rsp_mdata[WALK_TAG_BIT];
    assign rsp_tagged   = mem_rsp_valid && is_walk_rsp;
    assign rsp_data_out = mem_rsp_data;

    // Untagged responses go to the accelerator through one register stage.
    // Tagged ones never raise the accelerator valid
    always_ff @(posedge clk)
    begin
        afu_rsp_valid <= mem_rsp_valid && !is_walk_rsp;
        afu_rsp_mdata <= mem_rsp_mdata;
        afu_rsp_data  <= mem_rsp_data;

        if (reset)
        begin
            afu_rsp_valid <= 1'b0;
        end
    end

endmodule

// File: logic/write_heap.sv
module write_heap
    import mem_edge_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    // Fill port, driven by the accelerator
    input  logic              fill_en,
    input  logic [SLOT_W-1:0] fill_slot,
    input  logic [BEAT_W-1:0] fill_beat,
    input  logic [DATA_W-1:0] fill_data,

    // Read port, driven by the write beat expander
    input  logic [SLOT_W-1:0] rd_slot,
    input  logic [BEAT_W-1:0] rd_beat,
    output logic [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0]      mem [HEAP_DEPTH];

    logic                   fill_en_q;
    logic [HEAP_ADDR_W-1:0] fill_addr_q;
    logic [DATA_W-1:0]      fill_data_q;
    logic [HEAP_ADDR_W-1:0] rd_addr_q;

    // ====================
    // Fill port
    // ====================

    // Fill requests spend one cycle in a register before reaching the array
    always_ff @(posedge clk)
    begin
        fill_en_q   <= fill_en;
        fill_addr_q <= {fill_slot, fill_beat};
        fill_data_q <= fill_data;

        if (reset)
        begin
            fill_en_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en_q)
        begin
            mem[fill_addr_q] <= fill_data_q;
        end
    end

    // ====================
    // Read port
    // ====================

    // Address register then output register, two cycles from address to data
    always_ff @(posedge clk)
    begin
        rd_addr_q <= {rd_slot, rd_beat};
        rd_data   <= mem[rd_addr_q];
    end

endmodule

// File: logic/write_beat_expander.sv
module write_beat_expander
    import mem_edge_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    // Accelerator write requests
    input  logic              afu_wr_valid,
    input  logic [ADDR_W-1:0] afu_wr_addr,
    input  logic [BEAT_W-1:0] afu_wr_len,
    input  logic [SLOT_W-1:0] afu_wr_slot,
    output logic              afu_wr_ready,

    // Heap read port
    output logic [SLOT_W-1:0] heap_rd_slot,
    output logic [BEAT_W-1:0] heap_rd_beat,
    input  logic [DATA_W-1:0] heap_rd_data,

    // Memory write channel
    input  logic              mem_wr_almost_full,
    output logic              mem_wr_valid,
    output logic [ADDR_W-1:0] mem_wr_addr,
    output logic              mem_wr_sop,
    output logic [DATA_W-1:0] mem_wr_data,

    // Heap slot release
    output logic              slot_free,
    output logic [SLOT_W-1:0] slot_free_idx
);

    // Stage 1 holds the write being expanded
    logic              stg1_valid;
    logic [ADDR_W-1:0] stg1_addr;
    logic [SLOT_W-1:0] stg1_slot;
    logic [BEAT_W-1:0] stg1_beat;
    logic [BEAT_W-1:0] stg1_rem;

    // Stages 2 and 3 carry one beat each
    logic              stg2_valid;
    logic [ADDR_W-1:0] stg2_addr;
    logic              stg2_sop;
    logic              stg3_valid;
    logic [ADDR_W-1:0] stg3_addr;
    logic              stg3_sop;

    logic              may_fire;
    logic              beat_move;
    logic              packet_done;
    logic              take_req;

    // Slot release travels one cycle behind the last beat leaving stage 1
    logic              free_pend;
    logic [SLOT_W-1:0] free_pend_idx;

    // ====================
    // Stage 1 control
    // ====================

    assign may_fire    = !mem_wr_almost_full;
    assign beat_move   = stg1_valid && may_fire;

    // The last beat is the one with no beats remaining behind it
    assign packet_done = beat_move && (stg1_rem == '0);

    // A new write enters when stage 1 is empty or is emptying this cycle
    assign afu_wr_ready = !stg1_valid || packet_done;
    assign take_req     = afu_wr_valid && afu_wr_ready;

    // The heap address follows stage 1 so data is two cycles behind it
    assign heap_rd_slot = stg1_slot;
    assign heap_rd_beat = stg1_beat;

    always_ff @(posedge clk)
    begin
        if (take_req)
        begin
            stg1_valid <= 1'b1;
            stg1_addr  <= afu_wr_addr;
            stg1_slot  <= afu_wr_slot;
            stg1_beat  <= '0;
            stg1_rem   <= afu_wr_len;
        end
        else if (packet_done)
        begin
            stg1_valid <= 1'b0;
        end
        else if (beat_move)
        begin
            // Middle of a multi-beat write
            stg1_beat <= stg1_beat + 1'b1;
            stg1_rem  <= stg1_rem - 1'b1;
        end

        // Release the slot on the edge after its last beat has left stage 1,
        // in step with that beat reaching the memory write channel
        free_pend     <= packet_done;
        free_pend_idx <= stg1_slot;
        slot_free     <= free_pend;
        slot_free_idx <= free_pend_idx;

        if (reset)
        begin
            stg1_valid <= 1'b0;
            free_pend  <= 1'b0;
            slot_free  <= 1'b0;
        end
    end

    // ====================
    // Stages 2 and 3
    // ====================

    always_ff @(posedge clk)
    begin
        // Stage 2 takes a bubble while the memory channel is almost full
        stg2_valid <= beat_move;
        stg2_sop   <= (stg1_beat == '0);

        // Base address is aligned, so OR-ing the beat index selects the line
        stg2_addr  <= {stg1_addr[ADDR_W-1:BEAT_W], stg1_addr[BEAT_W-1:0] | stg1_beat};

        // Stage 3 lines up with the heap read data
        stg3_valid <= stg2_valid;
        stg3_addr  <= stg2_addr;
        stg3_sop   <= stg2_sop;

        if (reset)
        begin
            stg2_valid <= 1'b0;
            stg3_valid <= 1'b0;
        end
    end

    assign mem_wr_valid = stg3_valid;
    assign mem_wr_addr  = stg3_addr;
    assign mem_wr_sop   = stg3_sop;
    assign mem_wr_data  = heap_rd_data;

endmodule

// File: logic/mem_edge_top.sv
module mem_edge_top
    import mem_edge_pkg::*;
(
    input  logic               clk,
    input  logic               reset,

    // Accelerator read requests
    input  logic               afu_rd_valid,
    input  logic [ADDR_W-1:0]  afu_rd_addr,
    input  logic [MDATA_W-1:0] afu_rd_mdata,
    output logic               afu_rd_ready,

    // Memory read channel
    output logic               mem_rd_valid,
    output req_op_t            mem_rd_op,
    output logic [ADDR_W-1:0]  mem_rd_addr,
    output logic [MDATA_W-1:0] mem_rd_mdata,
    input  logic               mem_rd_almost_full,

    // Read responses
    input  logic               mem_rsp_valid,
    input  logic [MDATA_W-1:0] mem_rsp_mdata,
    input  logic [DATA_W-1:0]  mem_rsp_data,
    output logic               afu_rsp_valid,
    output logic [MDATA_W-1:0] afu_rsp_mdata,
    output logic [DATA_W-1:0]  afu_rsp_data,

    // Page table walker
    input  logic               walk_req,
    input  logic [ADDR_W-1:0]  walk_addr,
    output logic               walk_ack,
    output logic [DATA_W-1:0]  walk_data,

    // Write heap fill
    input  logic               heap_fill_en,
    input  logic [SLOT_W-1:0]  heap_fill_slot,
    input  logic [BEAT_W-1:0]  heap_fill_beat,
    input  logic [DATA_W-1:0]  heap_fill_data,

    // Accelerator write requests
    input  logic               afu_wr_valid,
    input  logic [ADDR_W-1:0]  afu_wr_addr,
    input  logic [BEAT_W-1:0]  afu_wr_len,
    input  logic [SLOT_W-1:0]  afu_wr_slot,
    output logic               afu_wr_ready,

    // Memory write channel
    output logic               mem_wr_valid,
    output logic [ADDR_W-1:0]  mem_wr_addr,
    output logic               mem_wr_sop,
    output logic [DATA_W-1:0]  mem_wr_data,
    input  logic               mem_wr_almost_full,

    // Slot release
    output logic               slot_free,
    output logic [SLOT_W-1:0]  slot_free_idx
);

    logic              walk_issue_valid;
    logic [ADDR_W-1:0] walk_issue_addr;
    logic              rsp_tagged;
    logic [DATA_W-1:0] rsp_data;
    logic [SLOT_W-1:0] heap_rd_slot;
    logic [BEAT_W-1:0] heap_rd_beat;
    logic [DATA_W-1:0] heap_rd_data;

    // ====================
    // Read path
    // ====================

    walk_read_port walk_port (
        .clk,
        .reset,
        .walk_req,
        .walk_addr,
        .rd_almost_full (mem_rd_almost_full),
        .rsp_tagged,
        .rsp_data,
        .walk_ack,
        .walk_data,
        .issue_valid    (walk_issue_valid),
        .issue_addr     (walk_issue_addr)
    );

    read_req_merge rd_merge (
        .afu_rd_valid,
        .afu_rd_addr,
        .afu_rd_mdata,
        .walk_issue_valid,
        .walk_issue_addr,
        .mem_rd_almost_full,
        .afu_rd_ready,
        .mem_rd_valid,
        .mem_rd_op,
        .mem_rd_addr,
        .mem_rd_mdata
    );

    read_rsp_steer rsp_steer (
        .clk,
        .reset,
        .mem_rsp_valid,
        .mem_rsp_mdata,
        .mem_rsp_data,
        .rsp_tagged,
        .rsp_data_out   (rsp_data),
        .afu_rsp_valid,
        .afu_rsp_mdata,
        .afu_rsp_data
    );

    // ====================
    // Write path
    // ====================

    write_heap heap (
        .clk,
        .reset,
        .fill_en        (heap_fill_en),
        .fill_slot      (heap_fill_slot),
        .fill_beat      (heap_fill_beat),
        .fill_data      (heap_fill_data),
        .rd_slot        (heap_rd_slot),
        .rd_beat        (heap_rd_beat),
        .rd_data        (heap_rd_data)
    );

    write_beat_expander wr_expand (
        .clk,
        .reset,
        .afu_wr_valid,
        .afu_wr_addr,
        .afu_wr_len,
        .afu_wr_slot,
        .mem_wr_almost_full,
        .heap_rd_data,
        .afu_wr_ready,
        .heap_rd_slot,
        .heap_rd_beat,
        .mem_wr_valid,
        .mem_wr_addr,
        .mem_wr_sop,
        .mem_wr_data,
        .slot_free,
        .slot_free_idx
    );

endmodule

// File: verif/tb_clock_gen.sv
module tb_clock_gen
(
    output logic clk,
    output logic reset
);

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;

    // Free running clock, half a period per phase
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset is released on a rising edge like any other synchronous input
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: verif/mem_edge_tb.sv
module mem_edge_tb
    import mem_edge_pkg::*;
();

    localparam int N_READS    = 40;
    localparam int N_WALKS    = 6;
    localparam int N_WRITES   = 16;
    localparam int SEED       = 6269;
    localparam int BEAT_REC_W = ADDR_W + 1 + DATA_W;
    localparam int RSP_REC_W  = MDATA_W + DATA_W;
    localparam logic [MDATA_W-1:0] WALK_MDATA = 1 << WALK_TAG_BIT;
    localparam logic [DATA_W-1:0]  LINE_KEY   = 64'h5A5A_C3C3_0F0F_9696;

    logic clk;
    logic reset;

    // DUT inputs
    logic               afu_rd_valid;
    logic [ADDR_W-1:0]  afu_rd_addr;
    logic [MDATA_W-1:0] afu_rd_mdata;
    logic               mem_rd_almost_full;
    logic               mem_rsp_valid;
    logic [MDATA_W-1:0] mem_rsp_mdata;
    logic [DATA_W-1:0]  mem_rsp_data;
    logic               walk_req;
    logic [ADDR_W-1:0]  walk_addr;
    logic               heap_fill_en;
    logic [SLOT_W-1:0]  heap_fill_slot;
    logic [BEAT_W-1:0]  heap_fill_beat;
    logic [DATA_W-1:0]  heap_fill_data;
    logic               afu_wr_valid;
    logic [ADDR_W-1:0]  afu_wr_addr;
    logic [BEAT_W-1:0]  afu_wr_len;
    logic [SLOT_W-1:0]  afu_wr_slot;
    logic               mem_wr_almost_full;

    // DUT outputs
    logic               afu_rd_ready;
    logic               mem_rd_valid;
    req_op_t            mem_rd_op;
    logic [ADDR_W-1:0]  mem_rd_addr;
    logic [MDATA_W-1:0] mem_rd_mdata;
    logic               afu_rsp_valid;
    logic [MDATA_W-1:0] afu_rsp_mdata;
    logic [DATA_W-1:0]  afu_rsp_data;
    logic               walk_ack;
    logic [DATA_W-1:0]  walk_data;
    logic               afu_wr_ready;
    logic               mem_wr_valid;
    logic [ADDR_W-1:0]  mem_wr_addr;
    logic               mem_wr_sop;
    logic [DATA_W-1:0]  mem_wr_data;
    logic               slot_free;
    logic [SLOT_W-1:0]  slot_free_idx;

    // Scoreboard state, owned by the comparing process unless noted
    logic [RSP_REC_W-1:0]  exp_rsp_q[$];
    logic [BEAT_REC_W-1:0] exp_beat_q[$];
    logic [SLOT_W-1:0]     exp_free_slot_q[$];
    int                    exp_free_end_q[$];
    logic [ADDR_W+MDATA_W+31:0] pend_q[$];
    logic [DATA_W-1:0]     heap_copy [HEAP_DEPTH];
    logic [BEAT_W-1:0]     wr_len [N_WRITES];
    logic [ADDR_W-1:0]     walk_cur_addr;
    logic                  af_enable;
    int walks_started   = 0;
    int walk_reads_seen = 0;
    int beats_accepted  = 0;
    int beats_seen      = 0;
    int slots_released  = 0;
    int mem_cycle       = 0;
    int last_due        = 0;
    int cycle_count     = 0;
    int limit           = 100000;
    int checks          = 0;
    int errors          = 0;

    tb_clock_gen clock_gen (
        .clk,
        .reset
    );

    mem_edge_top uut (.*);

    // ====================
    // Reference functions
    // ====================

    // Memory contents seen by reads, a fixed mix of the line address
    function automatic logic [DATA_W-1:0] line_value(input logic [ADDR_W-1:0] addr);
        return {{(DATA_W-ADDR_W){1'b0}}, addr} ^ LINE_KEY;
    endfunction

    // One write beat as {address, sop, data}, data taken from the heap copy
    function automatic logic [BEAT_REC_W-1:0] beat_expect(
        input logic [ADDR_W-1:0] base,
        input logic [SLOT_W-1:0] slot,
        input logic [BEAT_W-1:0] beat
    );
        logic [ADDR_W-1:0] addr;
        addr = base | ADDR_W'(beat);
        return {addr, (beat == 0), heap_copy[{slot, beat}]};
    endfunction

    // ====================
    // Reporting
    // ====================

    task automatic compare_value(
        input string             name,
        input logic [DATA_W-1:0] actual,
        input logic [DATA_W-1:0] expected
    );
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    endtask

    // ====================
    // Stimulus
    // ====================

    // Accelerator reads, reserved tag bit always clear
    task automatic run_reads();
        int i;
        for (i = 0; i < N_READS; i++)
        begin
            afu_rd_valid <= 1'b1;
            afu_rd_addr  <= $urandom;
            afu_rd_mdata <= MDATA_W'($urandom & 16'h7FFF);
            @(posedge clk);
            while (!afu_rd_ready) @(posedge clk);
        end
        afu_rd_valid <= 1'b0;
    endtask

    // Four-phase walker transactions with a short idle gap between them
    task automatic run_walks();
        int i;
        logic [ADDR_W-1:0] addr;
        for (i = 0; i < N_WALKS; i++)
        begin
            addr = $urandom;
            walk_cur_addr = addr;
            walks_started++;
            walk_req  <= 1'b1;
            walk_addr <= addr;
            @(posedge clk);
            while (!walk_ack) @(posedge clk);
            compare_value("walk_data", walk_data, line_value(addr));
            walk_req <= 1'b0;
            // Ack stays up one more cycle, then drops
            @(posedge clk);
            compare_value("walk_ack", walk_ack, 1'b1);
            @(posedge clk);
            compare_value("walk_ack", walk_ack, 1'b0);
            repeat ($urandom % 4) @(posedge clk);
        end
    endtask

    // Fill the heap slot, let the fill settle, then request the write.
    // A slot is refilled only after its previous user released it
    task automatic run_writes();
        int i;
        int k;
        logic [SLOT_W-1:0] slot;
        logic [ADDR_W-1:0] base;
        for (i = 0; i < N_WRITES; i++)
        begin
            slot = SLOT_W'(i % HEAP_SLOTS);
            while (slots_released < i - HEAP_SLOTS + 1) @(posedge clk);
            for (k = 0; k <= wr_len[i]; k++)
            begin
                heap_fill_en   <= 1'b1;
                heap_fill_slot <= slot;
                heap_fill_beat <= BEAT_W'(k);
                heap_fill_data <= {$urandom, $urandom};
                @(posedge clk);
            end
            heap_fill_en <= 1'b0;
            repeat (2) @(posedge clk);
            base = $urandom;
            base[BEAT_W-1:0] = '0;
            afu_wr_valid <= 1'b1;
            afu_wr_addr  <= base;
            afu_wr_len   <= wr_len[i];
            afu_wr_slot  <= slot;
            @(posedge clk);
            while (!afu_wr_ready) @(posedge clk);
            afu_wr_valid <= 1'b0;
        end
    endtask

    // ====================
    // Memory model
    // ====================

    // Random back pressure on both channels once traffic starts
    always @(posedge clk)
    begin
        mem_rd_almost_full <= af_enable && ($urandom % 4 == 0);
        mem_wr_almost_full <= af_enable && ($urandom % 4 == 0);
    end

    // In-order responses after 1 to 6 cycles, echoing the metadata
    always @(posedge clk)
    begin : memory_model
        int due;
        logic [ADDR_W+MDATA_W+31:0] entry;
        mem_cycle++;
        if (!reset && mem_rd_valid === 1'b1)
        begin
            due = mem_cycle + 1 + ($urandom % 6);
            if (due <= last_due)
                due = last_due + 1;
            last_due = due;
            pend_q.push_back({due, mem_rd_mdata, mem_rd_addr});
        end
        mem_rsp_valid <= 1'b0;
        if (pend_q.size() != 0 && int'(pend_q[0][ADDR_W+MDATA_W +: 32]) <= mem_cycle)
        begin
            entry = pend_q.pop_front();
            mem_rsp_valid <= 1'b1;
            mem_rsp_mdata <= entry[ADDR_W +: MDATA_W];
            mem_rsp_data  <= line_value(entry[ADDR_W-1:0]);
        end
    end

    // ====================
    // Comparing process
    // ====================

    always @(posedge clk)
    begin : compare_outputs
        int k;
        logic [RSP_REC_W-1:0]  rsp_rec;
        logic [BEAT_REC_W-1:0] beat_rec;
        if (!reset)
        begin
            if (heap_fill_en)
                heap_copy[{heap_fill_slot, heap_fill_beat}] = heap_fill_data;

            if (mem_rd_valid && mem_rd_almost_full)
                note_failure("read issued while mem_rd_almost_full was high");
            if (mem_rd_valid)
                compare_value("mem_rd_op", mem_rd_op, OP_RD_LINE);

            // A walker read holds the accelerator off, otherwise only back pressure does
            if (mem_rd_valid && mem_rd_mdata[WALK_TAG_BIT])
                compare_value("afu_rd_ready", afu_rd_ready, 1'b0);
            else
                compare_value("afu_rd_ready", afu_rd_ready, !mem_rd_almost_full);

            // Accepted reads pass through in the same cycle
            if (afu_rd_valid && afu_rd_ready)
            begin
                compare_value("mem_rd_valid", mem_rd_valid, 1'b1);
                compare_value("mem_rd_addr", mem_rd_addr, afu_rd_addr);
                compare_value("mem_rd_mdata", mem_rd_mdata, afu_rd_mdata);
                exp_rsp_q.push_back({afu_rd_mdata, line_value(afu_rd_addr)});
            end
            else if (mem_rd_valid && !mem_rd_mdata[WALK_TAG_BIT])
                note_failure("untagged memory read with no accepted accelerator read");

            // Walker reads, exactly one per walk
            if (mem_rd_valid && mem_rd_mdata[WALK_TAG_BIT])
            begin
                if (walk_reads_seen >= walks_started)
                    note_failure("walker read issued with no walk in progress");
                walk_reads_seen++;
                compare_value("mem_rd_mdata", mem_rd_mdata, WALK_MDATA);
                compare_value("mem_rd_addr", mem_rd_addr, walk_cur_addr);
            end

            if (afu_rsp_valid)
            begin
                compare_value("afu_rsp_mdata tag bit", afu_rsp_mdata[WALK_TAG_BIT], 1'b0);
                if (exp_rsp_q.size() == 0)
                    note_failure("accelerator response with no read outstanding");
                else
                begin
                    rsp_rec = exp_rsp_q.pop_front();
                    compare_value("afu_rsp_mdata", afu_rsp_mdata, rsp_rec[DATA_W +: MDATA_W]);
                    compare_value("afu_rsp_data", afu_rsp_data, rsp_rec[DATA_W-1:0]);
                end
            end

            // Accepted write expands into its beats and one slot release
            if (afu_wr_valid && afu_wr_ready)
            begin
                for (k = 0; k <= afu_wr_len; k++)
                    exp_beat_q.push_back(beat_expect(afu_wr_addr, afu_wr_slot, BEAT_W'(k)));
                beats_accepted += afu_wr_len + 1;
                exp_free_slot_q.push_back(afu_wr_slot);
                exp_free_end_q.push_back(beats_accepted);
            end

            if (mem_wr_valid)
            begin
                if (exp_beat_q.size() == 0)
                    note_failure("write beat appeared with no write outstanding");
                else
                begin
                    beat_rec = exp_beat_q.pop_front();
                    compare_value("mem_wr_addr", mem_wr_addr, beat_rec[DATA_W+1 +: ADDR_W]);
                    compare_value("mem_wr_sop", mem_wr_sop, beat_rec[DATA_W]);
                    compare_value("mem_wr_data", mem_wr_data, beat_rec[DATA_W-1:0]);
                end
                beats_seen++;
            end

            // Beats are handled first, so the last beat of this write is counted
            if (slot_free)
            begin
                if (exp_free_slot_q.size() == 0)
                    note_failure("slot released with no write outstanding");
                else
                begin
                    compare_value("slot_free_idx", slot_free_idx, exp_free_slot_q.pop_front());
                    if (beats_seen < exp_free_end_q.pop_front())
                        note_failure("slot released before the last beat of its write");
                end
                slots_released++;
            end
        end
    end

    // ====================
    // Run control
    // ====================

    initial
    begin : watchdog
        @(posedge clk);
        while (cycle_count < limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        note_failure($sformatf("timeout after %0d cycles, traffic never completed", cycle_count));
        finish_run();
    end

    initial
    begin : main
        int i;
        int total_beats;
        void'($urandom(SEED));
        afu_rd_valid       <= 1'b0;
        afu_rd_addr        <= '0;
        afu_rd_mdata       <= '0;
        mem_rd_almost_full <= 1'b0;
        mem_rsp_valid      <= 1'b0;
        mem_rsp_mdata      <= '0;
        mem_rsp_data       <= '0;
        walk_req           <= 1'b0;
        walk_addr          <= '0;
        heap_fill_en       <= 1'b0;
        heap_fill_slot     <= '0;
        heap_fill_beat     <= '0;
        heap_fill_data     <= '0;
        afu_wr_valid       <= 1'b0;
        afu_wr_addr        <= '0;
        afu_wr_len         <= '0;
        afu_wr_slot        <= '0;
        mem_wr_almost_full <= 1'b0;
        af_enable          <= 1'b0;

        // Write lengths are drawn up front so the run limit can be sized
        total_beats = 0;
        for (i = 0; i < N_WRITES; i++)
        begin
            wr_len[i] = BEAT_W'($urandom % MAX_BEATS);
            total_beats += wr_len[i] + 1;
        end
        limit = N_READS + N_WALKS * 10 + total_beats * 4 + 200;

        @(posedge clk);
        while (reset) @(posedge clk);

        // Idle outputs stay quiet before any stimulus
        repeat (4)
        begin
            @(posedge clk);
            compare_value("mem_rd_valid", mem_rd_valid, 1'b0);
            compare_value("mem_wr_valid", mem_wr_valid, 1'b0);
            compare_value("afu_rsp_valid", afu_rsp_valid, 1'b0);
            compare_value("walk_ack", walk_ack, 1'b0);
            compare_value("slot_free", slot_free, 1'b0);
        end

        af_enable <= 1'b1;
        fork
            run_reads();
            run_walks();
            run_writes();
        join

        // Drain, then watch a while longer for stray outputs
        while (exp_rsp_q.size() != 0 || exp_beat_q.size() != 0 || exp_free_slot_q.size() != 0)
            @(posedge clk);
        repeat (20) @(posedge clk);

        if (walk_reads_seen != N_WALKS)
            note_failure($sformatf("saw %0d walker reads for %0d walks", walk_reads_seen, N_WALKS));
        finish_run();
    end

endmodule

// File: sources.f
logic/mem_edge_pkg.sv
logic/walk_read_port.sv
logic/read_req_merge.sv
logic/read_rsp_steer.sv
logic/write_heap.sv
logic/write_beat_expander.sv
logic/mem_edge_top.sv
verif/tb_clock_gen.sv
verif/mem_edge_tb.sv
